/* relu_array_top.f */
hw/vec_fmt_pkg.sv
hw/flow_pkg.sv
hw/credit_fifo.sv
hw/beat_gather.sv
hw/word_dispatch.sv
hw/relu_lane.sv
hw/lane_drain.sv
hw/relu_array_top.sv
tests/relu_array_assertions.sv
tests/relu_array_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the ReLU array testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --assert -Wno-fatal \
    --top-module relu_array_tb \
    -Mdir "$BUILD_DIR" -o relu_array_sim \
    -f relu_array_top.f

"$BUILD_DIR"/relu_array_sim +verilator+error+limit+1000 | tee "$LOG"

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

/* tests/relu_array_tb.sv */
// ReLU array testbench that checks random credit traffic against a ReLU model
`timescale 1ns/1ps
`default_nettype none

module relu_array_tb
    import vec_fmt_pkg::*;
    import flow_pkg::*;
;

    localparam int num_words   = 200;
    localparam int total_beats = num_words * beats_per_word;
    localparam int run_limit   = 60000;
    localparam int drain_limit = 200;

    logic  clk = 1'b0;
    logic  rstn;
    beat_t in_data;
    logic  in_valid;
    logic  in_credit;
    beat_t out_data;
    logic  out_valid;
    logic  out_credit;

    logic [15:0] lfsr;
    beat_t       exp_q [$];
    int          errors;
    int          assert_fails;
    int          sent_beats;
    int          recv_beats;
    int          credit_pulses;
    int          up_credits;
    int          returned;
    int          owed;
    int          hold_left;
    int          cycles;

    relu_array_top dut (
        .clk        (clk),
        .rstn       (rstn),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_credit  (in_credit),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_credit (out_credit)
    );

    bind relu_array_top relu_array_assertions u_assert (
        .clk        (clk),
        .rstn       (rstn),
        .out_valid  (out_valid),
        .out_credit (out_credit),
        .lane_cnt   (u_dispatch.lane_cnt),
        .in_push    (in_valid),
        .in_full    (u_in_fifo.full),
        .res_valid  (res_valid),
        .res_take   (res_take),
        .res_word   (res_word)
    );

    always #4 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Every 10 words carry one all-negative, all-positive, zero and most-negative word
    function automatic beat_t make_beat(input int word_idx);
        beat_t       b;
        logic [31:0] r;
        b = '0;
        for (int e = 0; e < elems_per_beat; e++) begin
            case (word_idx % 10)
                2: begin
                    r = rand_bits(elem_w);
                    b[e*elem_w +: elem_w] = r[15:0] | 16'h8000;
                end
                4: begin
                    r = rand_bits(elem_w);
                    b[e*elem_w +: elem_w] = (r[15:0] & 16'h7FFF) | 16'h0001;
                end
                6: b[e*elem_w +: elem_w] = 16'h0000;
                8: b[e*elem_w +: elem_w] = 16'h8000;
                default: begin
                    r = rand_bits(elem_w);
                    b[e*elem_w +: elem_w] = r[15:0];
                end
            endcase
        end
        return b;
    endfunction

    // Reference ReLU rule zeroes negative elements
    function automatic beat_t relu_beat(input beat_t b);
        beat_t r;
        r = b;
        for (int e = 0; e < elems_per_beat; e++) begin
            if (b[e*elem_w + elem_w - 1]) begin
                r[e*elem_w +: elem_w] = '0;
            end
        end
        return r;
    endfunction

    task automatic check_quiet(input string when);
        if (in_credit !== 1'b0) begin
            errors++;
            $display("** Error at %0t: in_credit expected 0, got %b (%s)", $time, in_credit, when);
        end
        if (out_valid !== 1'b0) begin
            errors++;
            $display("** Error at %0t: out_valid expected 0, got %b (%s)", $time, out_valid, when);
        end
    endtask

    task automatic sample_outputs();
        beat_t exp_beat;
        if (in_credit) begin
            credit_pulses++;
            up_credits++;
            if (up_credits > in_depth) begin
                errors++;
                $display("** Error at %0t: up_credits expected <= %0d, got %0d",
                         $time, in_depth, up_credits);
            end
        end
        if (out_valid) begin
            recv_beats++;
            owed++;
            if (recv_beats > out_credits + returned) begin
                errors++;
                $display("** Error at %0t: out_valid beats expected <= %0d, got %0d",
                         $time, out_credits + returned, recv_beats);
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output beat %0d arrived with no beat left to expect", recv_beats);
            end else begin
                exp_beat = exp_q.pop_front();
                if (out_data !== exp_beat) begin
                    errors++;
                    $display("** Error at %0t: out_data expected %h, got %h",
                             $time, exp_beat, out_data);
                end
            end
        end
    endtask

    task automatic drive_inputs();
        beat_t b;
        in_valid = 1'b0;
        if ((sent_beats < total_beats) && (up_credits > 0) && rand_bits(1)) begin
            b = make_beat(sent_beats / beats_per_word);
            in_data  = b;
            in_valid = 1'b1;
            up_credits--;
            sent_beats++;
            exp_q.push_back(relu_beat(b));
        end
        // Downstream withholds credits in long stretches
        out_credit = 1'b0;
        if (hold_left > 0) begin
            hold_left--;
        end else if (rand_bits(4) == 0) begin
            hold_left = 8 + int'(rand_bits(6));
        end else if ((owed > 0) && rand_bits(1)) begin
            out_credit = 1'b1;
            owed--;
            returned++;
        end
    endtask

    initial begin
        lfsr          = 16'd16;
        rstn          = 1'b0;
        in_data       = '0;
        in_valid      = 1'b0;
        out_credit    = 1'b0;
        errors        = 0;
        sent_beats    = 0;
        recv_beats    = 0;
        credit_pulses = 0;
        up_credits    = in_depth;
        returned      = 0;
        owed          = 0;
        hold_left     = 0;

        repeat (10) begin
            @(negedge clk);
            check_quiet("during reset");
        end
        rstn = 1'b1;
        @(negedge clk);
        check_quiet("first cycle after reset");

        cycles = 0;
        while ((recv_beats < total_beats) && (cycles < run_limit)) begin
            sample_outputs();
            drive_inputs();
            @(negedge clk);
            cycles++;
        end
        if (recv_beats < total_beats) begin
            errors++;
            $display("Timeout: only %0d of %0d output beats arrived", recv_beats, total_beats);
        end

        // All input credits should come home
        cycles = 0;
        while ((up_credits != in_depth) && (cycles < drain_limit)) begin
            sample_outputs();
            drive_inputs();
            @(negedge clk);
            cycles++;
        end
        if (up_credits != in_depth) begin
            errors++;
            $display("Timeout: upstream credits stuck at %0d", up_credits);
        end

        // Quiet window catches duplicated beats
        repeat (32) begin
            sample_outputs();
            drive_inputs();
            @(negedge clk);
        end

        if (credit_pulses != sent_beats) begin
            errors++;
            $display("** Error at %0t: in_credit pulses expected %0d, got %0d",
                     $time, sent_beats, credit_pulses);
        end
        if (recv_beats != total_beats) begin
            errors++;
            $display("** Error at %0t: out_valid beats expected %0d, got %0d",
                     $time, total_beats, recv_beats);
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected beats never arrived", exp_q.size());
        end

        assert_fails = dut.u_assert.fail_cnt;
        $display("Summary: %0d beats checked, %0d errors, %0d assertion failures",
                 recv_beats, errors, assert_fails);
        if ((errors == 0) && (assert_fails == 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/relu_array_assertions.sv */
// ReLU array assertions on credit limits, FIFO overflow and result hold rules
`timescale 1ns/1ps
`default_nettype none

module relu_array_assertions
    import vec_fmt_pkg::*;
    import flow_pkg::*;
(
    input wire logic                 clk,
    input wire logic                 rstn,
    input wire logic                 out_valid,
    input wire logic                 out_credit,
    input wire logic [cnt_w-1:0]     lane_cnt [num_lanes],
    input wire logic                 in_push,
    input wire logic                 in_full,
    input wire logic [num_lanes-1:0] res_valid,
    input wire logic [num_lanes-1:0] res_take,
    input word_t                     res_word [num_lanes]
);

    int               fail_cnt = 0;
    logic [cnt_w-1:0] credit_model;

    // Downstream credit balance as seen at the top-level ports
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credit_model <= cnt_w'(out_credits);
        end else begin
            credit_model <= credit_model + cnt_w'(out_credit) - cnt_w'(out_valid);
        end
    end

    // Drain may only emit while it holds a credit
    out_valid_credit: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> (credit_model != '0))
        else begin
            $error("out_valid asserted with zero drain credits");
            fail_cnt++;
        end

    // Upstream credits must keep the input FIFO from overflowing
    in_push_full: assert property (@(posedge clk) disable iff (!rstn)
        in_push |-> !in_full)
        else begin
            $error("input FIFO pushed while full");
            fail_cnt++;
        end

    for (genvar i = 0; i < num_lanes; i++) begin : gen_lane_chk
        lane_cnt_max: assert property (@(posedge clk) disable iff (!rstn)
            lane_cnt[i] <= cnt_w'(lane_depth))
            else begin
                $error("lane %0d credit counter above lane depth", i);
                fail_cnt++;
            end

        // A result and its word are held until the drain takes it
        res_hold: assert property (@(posedge clk) disable iff (!rstn)
            (res_valid[i] && !res_take[i]) |=> (res_valid[i] && $stable(res_word[i])))
            else begin
                $error("lane %0d changed its result before it was taken", i);
                fail_cnt++;
            end
    end

endmodule

`default_nettype wire

/* hw/relu_array_top.sv */
// ReLU array top: input FIFO, gather, dispatcher, four lanes and drain
`timescale 1ns/1ps
`default_nettype none

module relu_array_top
    import vec_fmt_pkg::*;
    import flow_pkg::*;
(
    input  wire logic clk,
    input  wire logic rstn,
    input  beat_t     in_data,
    input  wire logic in_valid,
    output logic      in_credit,
    output beat_t     out_data,
    output logic      out_valid,
    input  wire logic out_credit
);

    beat_t                beat;
    logic                 beat_ready;
    logic                 beat_pop;
    logic                 pop_grant;
    word_t                word;
    logic                 word_valid;
    logic [num_lanes-1:0] lane_push;
    logic [num_lanes-1:0] lane_credit;
    logic [num_lanes-1:0] res_valid;
    logic [num_lanes-1:0] res_take;
    word_t                res_word [num_lanes];

    // Input beat buffer, each pop returns one upstream credit
    credit_fifo #(
        .payload_t (beat_t),
        .depth     (in_depth)
    ) u_in_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .push      (in_valid),
        .push_data (in_data),
        .pop       (beat_pop),
        .pop_data  (beat),
        .not_empty (beat_ready),
        .popped    (in_credit)
    );

    beat_gather u_gather (
        .clk        (clk),
        .rstn       (rstn),
        .beat       (beat),
        .beat_ready (beat_ready),
        .pop_grant  (pop_grant),
        .beat_pop   (beat_pop),
        .word       (word),
        .word_valid (word_valid)
    );

    word_dispatch u_dispatch (
        .clk         (clk),
        .rstn        (rstn),
        .word_valid  (word_valid),
        .beat_pop    (beat_pop),
        .pop_grant   (pop_grant),
        .lane_push   (lane_push),
        .lane_credit (lane_credit)
    );

    // Word is broadcast, lane_push selects the receiver
    for (genvar i = 0; i < num_lanes; i++) begin : gen_lane
        relu_lane u_lane (
            .clk         (clk),
            .rstn        (rstn),
            .push        (lane_push[i]),
            .push_word   (word),
            .lane_credit (lane_credit[i]),
            .res_valid   (res_valid[i]),
            .res_word    (res_word[i]),
            .res_take    (res_take[i])
        );
    end

    lane_drain u_drain (
        .clk        (clk),
        .rstn       (rstn),
        .res_valid  (res_valid),
        .res_word   (res_word),
        .res_take   (res_take),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_credit (out_credit)
    );

endmodule

`default_nettype wire

/* hw/lane_drain.sv */
// Round-robin result collector and parallel-to-series beat emitter
`timescale 1ns/1ps
`default_nettype none

module lane_drain
    import vec_fmt_pkg::*;
    import flow_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic [num_lanes-1:0]  res_valid,
    input  word_t                      res_word [num_lanes],
    output logic [num_lanes-1:0]       res_take,
    output beat_t                      out_data,
    output logic                       out_valid,
    input  wire logic                  out_credit
);

    beat_t                 slots [beats_per_word];
    logic [slot_w-1:0]     seg;
    logic [lane_sel_w-1:0] exp_lane;
    logic [cnt_w-1:0]      credits;
    logic                  busy;
    logic                  emit;
    logic                  last_beat;
    logic                  load;

    // A beat goes out whenever a word is held and a credit is left
    assign emit      = busy && (credits != '0);
    assign last_beat = emit && (seg == slot_w'(beats_per_word - 1));

    // Reload straight after the final beat so words can run back to back
    assign load = res_valid[exp_lane] && (!busy || last_beat);

    always_comb begin
        res_take           = '0;
        res_take[exp_lane] = load;
    end

    assign out_valid = emit;
    assign out_data  = slots[seg];

    always_ff @(posedge clk) begin
        if (load) begin
            for (int b = 0; b < beats_per_word; b++) begin
                slots[b] <= res_word[exp_lane][b*beat_w +: beat_w];
            end
        end
    end

    // Segment counter and round-robin pointer
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy     <= 1'b0;
            seg      <= '0;
            exp_lane <= '0;
        end else begin
            if (load) begin
                busy     <= 1'b1;
                seg      <= '0;
                exp_lane <= (exp_lane == lane_sel_w'(num_lanes - 1)) ? '0 : exp_lane + 1'b1;
            end else begin
                if (last_beat) begin
                    busy <= 1'b0;
                end
                if (emit) begin
                    seg <= seg + 1'b1;
                end
            end
        end
    end

    // Output credits: spent per beat, returned per out_credit pulse
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credits <= cnt_w'(out_credits);
        end else begin
            credits <= credits + cnt_w'(out_credit) - cnt_w'(emit);
        end
    end

endmodule

`default_nettype wire

/* hw/relu_lane.sv */
// ReLU lane: word FIFO followed by a registered ReLU holding stage
`timescale 1ns/1ps
`default_nettype none

module relu_lane
    import vec_fmt_pkg::*;
    import flow_pkg::*;
(
    input  wire logic clk,
    input  wire logic rstn,
    input  wire logic push,
    input  word_t     push_word,
    output logic      lane_credit,
    output logic      res_valid,
    output word_t     res_word,
    input  wire logic res_take
);

    word_t fifo_word;
    word_t relu_word;
    logic  fifo_ready;
    logic  fifo_pop;

    credit_fifo #(
        .payload_t (word_t),
        .depth     (lane_depth)
    ) u_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .push      (push),
        .push_data (push_word),
        .pop       (fifo_pop),
        .pop_data  (fifo_word),
        .not_empty (fifo_ready),
        .popped    (lane_credit)
    );

    // Move a word only when the holding register frees up this cycle
    assign fifo_pop = fifo_ready && (!res_valid || res_take);

    // Clamp each negative element to zero
    for (genvar e = 0; e < elems_per_word; e++) begin : gen_relu
        elem_t elem;
        assign elem = fifo_word[e*elem_w +: elem_w];
        assign relu_word[e*elem_w +: elem_w] = (elem < 0) ? '0 : elem;
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            res_word <= relu_word;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else if (fifo_pop) begin
            res_valid <= 1'b1;
        end else if (res_take) begin
            res_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/word_dispatch.sv */
// Round-robin word dispatcher with per-lane credit counters
`timescale 1ns/1ps
`default_nettype none

module word_dispatch
    import vec_fmt_pkg::*;
    import flow_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  word_valid,
    input  wire logic                  beat_pop,
    output logic                       pop_grant,
    output logic [num_lanes-1:0]       lane_push,
    input  wire logic [num_lanes-1:0]  lane_credit
);

    logic [cnt_w-1:0]      lane_cnt [num_lanes];
    logic [lane_sel_w-1:0] tgt;
    logic [slot_w-1:0]     beat_cnt;
    logic                  busy;
    logic                  reserve;

    // First beat of a word claims a slot in the target lane
    assign reserve = beat_pop && !busy;

    // Once reserved, keep granting until all four beats are out, then
    // hold off until the word itself has been steered
    assign pop_grant = busy ? (beat_cnt != '0) : (lane_cnt[tgt] != '0);

    always_comb begin
        lane_push      = '0;
        lane_push[tgt] = word_valid;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tgt      <= '0;
            beat_cnt <= '0;
            busy     <= 1'b0;
            for (int i = 0; i < num_lanes; i++) begin
                lane_cnt[i] <= cnt_w'(lane_depth);
            end
        end else begin
            if (beat_pop) begin
                beat_cnt <= (beat_cnt == slot_w'(beats_per_word - 1)) ? '0 : beat_cnt + 1'b1;
            end
            if (reserve) begin
                busy <= 1'b1;
            end else if (word_valid) begin
                busy <= 1'b0;
            end
            if (word_valid) begin
                tgt <= (tgt == lane_sel_w'(num_lanes - 1)) ? '0 : tgt + 1'b1;
            end
            for (int i = 0; i < num_lanes; i++) begin
                lane_cnt[i] <= lane_cnt[i] + cnt_w'(lane_credit[i])
                               - cnt_w'(reserve && (tgt == lane_sel_w'(i)));
            end
        end
    end

endmodule

`default_nettype wire

/* hw/beat_gather.sv */
// Series-to-parallel packer that collects four beats into one word
`timescale 1ns/1ps
`default_nettype none

module beat_gather
    import vec_fmt_pkg::*;
(
    input  wire logic clk,
    input  wire logic rstn,
    input  beat_t     beat,
    input  wire logic beat_ready,
    input  wire logic pop_grant,
    output logic      beat_pop,
    output word_t     word,
    output logic      word_valid
);

    beat_t             slots [beats_per_word];
    logic [slot_w-1:0] slot;
    logic              last_slot;

    assign beat_pop  = pop_grant && beat_ready;
    assign last_slot = (slot == slot_w'(beats_per_word - 1));

    // Slot counter walks 0..3 and wraps
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot       <= '0;
            word_valid <= 1'b0;
        end else begin
            if (beat_pop) begin
                slot <= last_slot ? '0 : slot + 1'b1;
            end
            word_valid <= beat_pop && last_slot;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_pop) begin
            slots[slot] <= beat;
        end
    end

    // Beat 0 in the low bits
    for (genvar b = 0; b < beats_per_word; b++) begin : gen_pack
        assign word[b*beat_w +: beat_w] = slots[b];
    end

endmodule

`default_nettype wire

/* hw/credit_fifo.sv */
// Synchronous circular FIFO with a registered pop pulse for credit return
`timescale 1ns/1ps
`default_nettype none

module credit_fifo
    import flow_pkg::*;
#(
    parameter type payload_t = logic,
    parameter int  depth     = lane_depth
) (
    input  wire logic clk,
    input  wire logic rstn,
    input  wire logic push,
    input  payload_t  push_data,
    input  wire logic pop,
    output payload_t  pop_data,
    output logic      not_empty,
    output logic      popped
);

    localparam int ptr_w  = (depth > 1) ? $clog2(depth) : 1;
    localparam int fill_w = $clog2(depth + 1);

    payload_t          mem [depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [fill_w-1:0] count;
    logic              full;
    logic              do_push;
    logic              do_pop;

    assign full      = (count == fill_w'(depth));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;

    // Show-ahead read port
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            popped <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + fill_w'(do_push) - fill_w'(do_pop);
            // One credit back per entry that left
            popped <= do_pop;
        end
    end

endmodule

`default_nettype wire

/* hw/flow_pkg.sv */
// Flow control sizing: FIFO depths, credit counts and lane count
`default_nettype none

package flow_pkg;

    // Parallel ReLU lanes and the width of a lane index
    localparam int num_lanes  = 4;
    localparam int lane_sel_w = $clog2(num_lanes);

    // Input FIFO depth, equal to the credits upstream holds after reset
    localparam int in_depth = 8;

    // Word FIFO depth per lane, equal to the dispatcher's initial lane credit
    localparam int lane_depth = 2;

    // Beat credits the drain holds after reset
    localparam int out_credits = 4;

    // Width of every credit counter
    localparam int cnt_w = 4;

endpackage

`default_nettype wire

/* hw/vec_fmt_pkg.sv */
// Vector data format: beats, words and signed elements
`default_nettype none

package vec_fmt_pkg;

    // One upstream beat carries four signed elements
    localparam int beat_w         = 64;
    localparam int elem_w         = 16;
    localparam int elems_per_beat = beat_w / elem_w;

    // One datapath word is four beats wide
    localparam int beats_per_word = 4;
    localparam int word_w         = beat_w * beats_per_word;
    localparam int elems_per_word = elems_per_beat * beats_per_word;

    // Index of a beat inside a word
    localparam int slot_w = $clog2(beats_per_word);

    typedef logic [beat_w-1:0] beat_t;

    // Beat 0 in the low bits, element 0 of each beat in its low bits
    typedef logic [word_w-1:0] word_t;

    typedef logic signed [elem_w-1:0] elem_t;

endpackage

`default_nettype wire
